/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal -j 0
TOP       ?= core_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "no pass message in log"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module core_tb;

  import params_pkg::*;
  import isa_pkg::*;

  localparam int HALT_ADDR  = 8'h80;
  localparam int SPARE_ADDR = 8'hc0;   // never fetched

  logic         clk_i;
  logic         rst_i;
  logic         load_we_i;
  addr_t        load_addr_i;
  instruction_t load_data_i;
  wb_t          wb_o;
  logic         retire_valid_o;
  addr_t        retire_pc_o;
  logic         branch_taken_o;
  logic         is_jump_o;

  integer       seed;
  int           errors;
  int           retired;
  int           wb_seen;
  int           cycles;
  int           limit;

  instruction_t prog [MEM_SIZE];
  bit           used [MEM_SIZE];
  addr_t        ptr;

  addr_t        exp_pc_q [$];
  logic [1:0]   exp_flow_q [$];   // {branch taken, jump}
  wb_t          exp_wb_q [$];

  core_top dut_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .load_we_i      (load_we_i),
    .load_addr_i    (load_addr_i),
    .load_data_i    (load_data_i),
    .wb_o           (wb_o),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .branch_taken_o (branch_taken_o),
    .is_jump_o      (is_jump_o)
  );

  always #20 clk_i = ~clk_i;

  function automatic instruction_t alu_word(opcode_t op, int rd, int rs1, int rs2);
    return {op, 3'(rd), 3'(rs1), 3'(rs2), 3'b000};
  endfunction

  function automatic instruction_t imm_word(opcode_t op, int rd, int rs1, int imm);
    return {op, 3'(rd), 3'(rs1), 6'(imm)};
  endfunction

  function automatic instruction_t jump_word(int target);
    return {JMP, 4'b0000, addr_t'(target)};
  endfunction

  function automatic instruction_t random_alu_word();
    int pick;
    int rd;
    int rs1;
    int rs2;
    pick = $unsigned($random(seed)) % 5;
    rd   = $unsigned($random(seed)) % REG_COUNT;   // r0 included on purpose
    rs1  = $unsigned($random(seed)) % REG_COUNT;
    rs2  = $unsigned($random(seed)) % REG_COUNT;
    case (pick)
      0:       return alu_word(ADD, rd, rs1, rs2);
      1:       return alu_word(SUB, rd, rs1, rs2);
      2:       return alu_word(AND, rd, rs1, rs2);
      3:       return alu_word(XOR, rd, rs1, rs2);
      default: return imm_word(ADDI, rd, rs1, $random(seed));
    endcase
  endfunction

  task automatic place_word(instruction_t word);
    prog[ptr] = word;
    used[ptr] = 1'b1;
    ptr       = ptr + 1'b1;
  endtask

  task automatic build_program();
    ptr = addr_t'(RESET_PC);
    for (int r = 1; r < REG_COUNT; r++) begin
      place_word(imm_word(ADDI, r, 0, $random(seed)));
    end
    repeat (12) place_word(random_alu_word());
    place_word(imm_word(ADDI, 0, 3, 5));     // r0 destination
    place_word(alu_word(ADD, 2, 0, 4));      // r0 source
    place_word(alu_word(SUB, 6, 4, 0));
    place_word('0);                          // nop
    place_word(imm_word(ADDI, 7, 0, 1));
    place_word(imm_word(BEQ, 7, 0, 3));      // 1 vs 0, falls through
    place_word(random_alu_word());
    place_word(imm_word(BEQ, 5, 5, 3));      // always taken, skips two
    place_word(imm_word(ADDI, 1, 1, 1));
    place_word(imm_word(ADDI, 2, 2, 1));
    repeat (4) place_word(random_alu_word());
    place_word(jump_word(8'h60));
    place_word(imm_word(ADDI, 3, 3, 7));     // shadow of the jump
    ptr = 8'h60;
    repeat (4) place_word(random_alu_word());
    place_word(imm_word(BEQ, 0, 0, -16));    // backward to 0x54
    place_word(imm_word(ADDI, 4, 4, 1));
    ptr = 8'h54;
    repeat (3) place_word(random_alu_word());
    place_word(jump_word(HALT_ADDR));
    ptr = HALT_ADDR;
    place_word(jump_word(HALT_ADDR));        // spins here
  endtask

  // walks the program in order and queues what should retire
  task automatic run_model();
    data_t        regs [REG_COUNT];
    addr_t        pc;
    addr_t        next;
    instruction_t w;
    opcode_t      op;
    int           rd;
    int           rs1;
    int           rs2;
    data_t        imm;
    data_t        res;
    logic [1:0]   flow;
    wb_t          wb;
    bit           halted;
    for (int r = 0; r < REG_COUNT; r++) begin
      regs[r] = '0;
    end
    pc     = addr_t'(RESET_PC);
    halted = 1'b0;
    while (!halted && exp_pc_q.size() < 400) begin
      w    = prog[pc];
      op   = opcode_t'(w[15:12]);
      rd   = w[11:9];
      rs1  = w[8:6];
      rs2  = w[5:3];
      imm  = {{10{w[5]}}, w[5:0]};
      res  = '0;
      flow = 2'b00;
      next = pc + 1'b1;
      case (op)
        ADD:  res = regs[rs1] + regs[rs2];
        SUB:  res = regs[rs1] - regs[rs2];
        AND:  res = regs[rs1] & regs[rs2];
        XOR:  res = regs[rs1] ^ regs[rs2];
        ADDI: res = regs[rs1] + imm;
        BEQ: begin
          if (regs[rd] == regs[rs1]) begin
            flow = 2'b10;
            next = pc + imm[7:0];
          end
        end
        JMP: begin
          flow   = 2'b01;
          next   = w[7:0];
          halted = (next == pc);
        end
        default: res = '0;
      endcase
      exp_pc_q.push_back(pc);
      exp_flow_q.push_back(flow);
      if ((op inside {ADD, SUB, AND, XOR, ADDI}) && rd != 0) begin
        regs[rd] = res;
        wb.valid = 1'b1;
        wb.rd    = reg_idx_t'(rd);
        wb.data  = res;
        exp_wb_q.push_back(wb);
      end
      pc = next;
    end
  endtask

  task automatic finish_run(bit timed_out);
    $display("checked %0d retires, %0d writebacks, %0d errors", retired, wb_seen, errors);
    if (errors == 0 && !timed_out) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  always @(negedge clk_i) begin
    if (rst_i) begin
      if (retire_valid_o) begin
        assert (exp_pc_q.size() != 0) else begin
          errors++;
          $display("unexpected retire of pc %0d at %0t", retire_pc_o, $time);
        end
        if (exp_pc_q.size() != 0) begin
          assert (retire_pc_o == exp_pc_q[0]) else begin
            errors++;
            $display("ERR %0t: retired pc %0d, expected %0d", $time, retire_pc_o,
                     exp_pc_q[0]);
          end
          assert ({branch_taken_o, is_jump_o} == exp_flow_q[0]) else begin
            errors++;
            $display("ERR %0t: pc %0d branch/jump %b, expected %b", $time, retire_pc_o,
                     {branch_taken_o, is_jump_o}, exp_flow_q[0]);
          end
          void'(exp_pc_q.pop_front());
          void'(exp_flow_q.pop_front());
          retired++;
        end
      end
      if (!retire_valid_o) begin
        assert (!branch_taken_o && !is_jump_o) else begin
          errors++;
          $display("branch or jump pulse without a retire at %0t", $time);
        end
      end
      if (wb_o.valid) begin
        assert (exp_wb_q.size() != 0) else begin
          errors++;
          $display("unexpected writeback to r%0d at %0t", wb_o.rd, $time);
        end
        if (exp_wb_q.size() != 0) begin
          assert (wb_o.rd == exp_wb_q[0].rd && wb_o.data == exp_wb_q[0].data) else begin
            errors++;
            $display("ERR %0t: writeback r%0d = %h, expected r%0d = %h", $time, wb_o.rd,
                     wb_o.data, exp_wb_q[0].rd, exp_wb_q[0].data);
          end
          void'(exp_wb_q.pop_front());
          wb_seen++;
        end
      end
    end
  end

  // load port writes to spare words while the program runs
  initial begin
    wait (rst_i === 1'b1);
    while (retired < 6) @(posedge clk_i);
    @(negedge clk_i);
    for (int i = 0; i < 3; i++) begin
      load_we_i   = 1'b1;
      load_addr_i = addr_t'(SPARE_ADDR + i);
      load_data_i = $random(seed);
      @(negedge clk_i);
    end
    load_we_i = 1'b0;
    while (retired < 20) @(posedge clk_i);
    @(negedge clk_i);
    load_we_i   = 1'b1;
    load_addr_i = addr_t'(SPARE_ADDR + 8);
    load_data_i = $random(seed);
    @(negedge clk_i);
    load_we_i = 1'b0;
  end

  initial begin
    bit timed_out;
    clk_i       = 1'b0;
    rst_i       = 1'b0;
    load_we_i   = 1'b0;
    load_addr_i = '0;
    load_data_i = '0;
    seed        = 32'hbc405929;
    errors      = 0;
    retired     = 0;
    wb_seen     = 0;
    cycles      = 0;
    build_program();
    run_model();
    limit = 8 * exp_pc_q.size() + 200;

    @(negedge clk_i);
    for (int a = 0; a < MEM_SIZE; a++) begin
      if (used[a]) begin
        load_we_i   = 1'b1;
        load_addr_i = addr_t'(a);
        load_data_i = prog[a];
        @(negedge clk_i);
      end
    end
    load_we_i = 1'b0;
    repeat (4) @(negedge clk_i);
    assert (!wb_o.valid && !retire_valid_o && !branch_taken_o && !is_jump_o) else begin
      errors++;
      $display("ERR %0t: core outputs active during reset", $time);
    end
    rst_i = 1'b1;

    while ((exp_pc_q.size() != 0 || exp_wb_q.size() != 0) && cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    timed_out = (exp_pc_q.size() != 0 || exp_wb_q.size() != 0);
    if (timed_out) begin
      $display("timeout after %0d cycles with %0d retires still expected", cycles,
               exp_pc_q.size());
    end
    finish_run(timed_out);
  end

endmodule : core_tb

`default_nettype wire

/* hdl/core_top.sv */
`timescale 1ns/10ps
`default_nettype none

module core_top (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic                  load_we_i,
  input  wire params_pkg::addr_t     load_addr_i,
  input  wire isa_pkg::instruction_t load_data_i,
  output isa_pkg::wb_t               wb_o,
  output logic                       retire_valid_o,
  output params_pkg::addr_t          retire_pc_o,
  output logic                       branch_taken_o,
  output logic                       is_jump_o
);

  import params_pkg::*;
  import isa_pkg::*;

  logic         mem_busy;
  logic         rd_req_valid;
  addr_t        mem_req_addr;
  logic         instr_valid;
  instruction_t mem_instr;

  logic         dec_valid;
  addr_t        dec_pc;
  instruction_t dec_instr;

  reg_idx_t     rs1;
  reg_idx_t     rs2;
  data_t        rs1_data;
  data_t        rs2_data;

  addr_t        branch_target;
  addr_t        jump_addr;

  fetch_stage u_fetch (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .mem_req_i          (mem_busy),
    .alu_branch_taken_i (branch_taken_o),
    .is_jump_i          (is_jump_o),
    .pc_branch_offset_i (branch_target),
    .jump_address_i     (jump_addr),
    .instr_valid_i      (instr_valid),
    .instr_i            (mem_instr),
    .rd_req_valid_o     (rd_req_valid),
    .dec_valid_o        (dec_valid),
    .mem_req_addr_o     (mem_req_addr),
    .dec_pc_o           (dec_pc),
    .instruction_o      (dec_instr)
  );

  imem u_imem (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .load_we_i     (load_we_i),
    .load_addr_i   (load_addr_i),
    .load_data_i   (load_data_i),
    .rd_req_i      (rd_req_valid),
    .rd_addr_i     (mem_req_addr),
    .busy_o        (mem_busy),
    .instr_valid_o (instr_valid),
    .instr_o       (mem_instr)
  );

  regfile u_regfile (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_i       (wb_o)
  );

  execute_unit u_execute (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .dec_valid_i     (dec_valid),
    .instruction_i   (dec_instr),
    .dec_pc_i        (dec_pc),
    .rs1_o           (rs1),
    .rs2_o           (rs2),
    .rs1_data_i      (rs1_data),
    .rs2_data_i      (rs2_data),
    .wb_o            (wb_o),
    .retire_valid_o  (retire_valid_o),
    .retire_pc_o     (retire_pc_o),
    .branch_taken_o  (branch_taken_o),
    .is_jump_o       (is_jump_o),
    .branch_target_o (branch_target),
    .jump_addr_o     (jump_addr)
  );

endmodule : core_top

`default_nettype wire

/* hdl/execute_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic                  dec_valid_i,
  input  wire isa_pkg::instruction_t instruction_i,
  input  wire params_pkg::addr_t     dec_pc_i,
  output params_pkg::reg_idx_t       rs1_o,
  output params_pkg::reg_idx_t       rs2_o,
  input  wire params_pkg::data_t     rs1_data_i,
  input  wire params_pkg::data_t     rs2_data_i,
  output isa_pkg::wb_t               wb_o,
  output logic                       retire_valid_o,
  output params_pkg::addr_t          retire_pc_o,
  output logic                       branch_taken_o,
  output logic                       is_jump_o,
  output params_pkg::addr_t          branch_target_o,
  output params_pkg::addr_t          jump_addr_o
);

  import params_pkg::*;
  import isa_pkg::*;

  opcode_t  op;
  reg_idx_t rd;
  imm6_t    imm6;
  addr_t    jaddr;
  data_t    imm_data;
  addr_t    imm_addr;
  addr_t    branch_target_d;
  data_t    alu_result;
  logic     alu_op;
  logic     operands_eq;
  logic     wb_valid_d;

  assign op    = opcode_of(instruction_i);
  assign rd    = rd_of(instruction_i);
  assign imm6  = imm6_of(instruction_i);
  assign jaddr = jaddr_of(instruction_i);

  assign rs1_o = rs1_of(instruction_i);
  assign rs2_o = (op == BEQ) ? rd : rs2_of(instruction_i);  // beq reads rd as second operand

  assign imm_data = {{(DATA_WIDTH - IMM_WIDTH){imm6[IMM_WIDTH-1]}}, imm6};
  assign imm_addr = {{(ADDR_WIDTH - IMM_WIDTH){imm6[IMM_WIDTH-1]}}, imm6};

  assign branch_target_d = dec_pc_i + imm_addr;   // wraps at MEM_SIZE
  assign operands_eq     = (rs1_data_i == rs2_data_i);

  always_comb begin
    alu_result = '0;
    alu_op     = 1'b1;
    case (op)
      ADD:     alu_result = rs1_data_i + rs2_data_i;
      SUB:     alu_result = rs1_data_i - rs2_data_i;
      AND:     alu_result = rs1_data_i & rs2_data_i;
      XOR:     alu_result = rs1_data_i ^ rs2_data_i;
      ADDI:    alu_result = rs1_data_i + imm_data;
      default: alu_op     = 1'b0;   // nop, beq, jmp and unused codes
    endcase
  end

  assign wb_valid_d = dec_valid_i && alu_op && (rd != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      wb_o.valid     <= 1'b0;
      retire_valid_o <= 1'b0;
      branch_taken_o <= 1'b0;
      is_jump_o      <= 1'b0;
    end else begin
      wb_o.valid     <= wb_valid_d;
      retire_valid_o <= dec_valid_i;
      branch_taken_o <= dec_valid_i && (op == BEQ) && operands_eq;
      is_jump_o      <= dec_valid_i && (op == JMP);
    end

    if (dec_valid_i) begin
      wb_o.rd         <= rd;
      wb_o.data       <= alu_result;
      retire_pc_o     <= dec_pc_i;
      branch_target_o <= branch_target_d;
      jump_addr_o     <= jaddr;
    end
  end

endmodule : execute_unit

`default_nettype wire

/* hdl/fetch_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic                  mem_req_i,           // imem busy, hold the request
  input  wire logic                  alu_branch_taken_i,
  input  wire logic                  is_jump_i,
  input  wire params_pkg::addr_t     pc_branch_offset_i,  // resolved branch target
  input  wire params_pkg::addr_t     jump_address_i,
  input  wire logic                  instr_valid_i,
  input  wire isa_pkg::instruction_t instr_i,
  output logic                       rd_req_valid_o,
  output logic                       dec_valid_o,
  output params_pkg::addr_t          mem_req_addr_o,
  output params_pkg::addr_t          dec_pc_o,
  output isa_pkg::instruction_t      instruction_o
);

  import params_pkg::*;
  import isa_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    MEM_REQ,
    MEM_WAIT,
    FLUSH
  } state_t;

  state_t state_q;
  state_t state_d;
  addr_t  pc_q;
  addr_t  pc_d;
  addr_t  next_pc;
  addr_t  target_q;       // captured branch or jump target
  addr_t  redirect_pc;
  logic   redirect;
  logic   dec_valid_d;

  assign redirect       = alu_branch_taken_i | is_jump_i;
  assign redirect_pc    = alu_branch_taken_i ? pc_branch_offset_i : jump_address_i;  // branch wins
  assign next_pc        = pc_q + 1'b1;   // wraps at MEM_SIZE
  assign mem_req_addr_o = pc_q;

  always_comb begin
    state_d        = state_q;
    pc_d           = pc_q;
    rd_req_valid_o = 1'b0;
    dec_valid_d    = 1'b0;

    case (state_q)
      IDLE: begin
        state_d = MEM_REQ;
      end
      MEM_REQ: begin
        if (redirect) begin
          pc_d = redirect_pc;       // stalled, nothing in flight to drain
        end else if (!mem_req_i) begin
          rd_req_valid_o = 1'b1;
          state_d        = MEM_WAIT;
        end
      end
      MEM_WAIT: begin
        if (redirect) begin
          if (instr_valid_i) begin  // word already back, drop it now
            pc_d    = redirect_pc;
            state_d = MEM_REQ;
          end else begin
            state_d = FLUSH;
          end
        end else if (instr_valid_i) begin
          dec_valid_d = 1'b1;
          pc_d        = next_pc;
          state_d     = MEM_REQ;
        end
      end
      FLUSH: begin
        if (instr_valid_i) begin    // stale word is discarded here
          pc_d    = target_q;
          state_d = MEM_REQ;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q     <= IDLE;
      pc_q        <= addr_t'(RESET_PC);
      dec_valid_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      pc_q        <= pc_d;
      dec_valid_o <= dec_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (redirect) begin
      target_q <= redirect_pc;
    end
    if (dec_valid_d) begin
      dec_pc_o      <= pc_q;
      instruction_o <= instr_i;
    end
  end

endmodule : fetch_stage

`default_nettype wire

/* hdl/imem.sv */
`timescale 1ns/10ps
`default_nettype none

module imem (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic                  load_we_i,
  input  wire params_pkg::addr_t     load_addr_i,
  input  wire isa_pkg::instruction_t load_data_i,
  input  wire logic                  rd_req_i,
  input  wire params_pkg::addr_t     rd_addr_i,
  output logic                       busy_o,
  output logic                       instr_valid_o,
  output isa_pkg::instruction_t      instr_o
);

  import params_pkg::*;
  import isa_pkg::*;

  instruction_t mem_q [MEM_SIZE];
  addr_t        rd_addr_q;
  logic         rd_pend_q;     // first read stage holds an address
  logic         load_we_q;

  // load port, independent of reset
  always_ff @(posedge clk_i) begin
    if (load_we_i) begin
      mem_q[load_addr_i] <= load_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      rd_pend_q     <= 1'b0;
      instr_valid_o <= 1'b0;
      load_we_q     <= 1'b0;
    end else begin
      rd_pend_q     <= rd_req_i;
      instr_valid_o <= rd_pend_q;
      load_we_q     <= load_we_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_req_i) begin
      rd_addr_q <= rd_addr_i;           // stage 1
    end
    if (rd_pend_q) begin
      instr_o <= mem_q[rd_addr_q];      // stage 2
    end
  end

  assign busy_o = load_we_i | load_we_q;  // write cycle plus one

endmodule : imem

`default_nettype wire

/* hdl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  import params_pkg::*;

  localparam int OPCODE_WIDTH = 4;
  localparam int IMM_WIDTH    = 6;

  typedef logic [DATA_WIDTH-1:0]          instruction_t;  // same width as data_t
  typedef logic signed [IMM_WIDTH-1:0]    imm6_t;

  // BEQ compares the registers named by rd and rs1, imm6 is the pc offset
  typedef enum logic [OPCODE_WIDTH-1:0] {
    NOP  = 4'h0,
    ADD  = 4'h1,
    SUB  = 4'h2,
    AND  = 4'h3,
    XOR  = 4'h4,
    ADDI = 4'h5,   // rd = rs1 + sext(imm6)
    BEQ  = 4'h6,
    JMP  = 4'h7    // pc = jaddr
  } opcode_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    data_t    data;
  } wb_t;

  function automatic opcode_t opcode_of(instruction_t instr);
    return opcode_t'(instr[15:12]);
  endfunction

  function automatic reg_idx_t rd_of(instruction_t instr);
    return instr[11:9];
  endfunction

  function automatic reg_idx_t rs1_of(instruction_t instr);
    return instr[8:6];
  endfunction

  function automatic reg_idx_t rs2_of(instruction_t instr);
    return instr[5:3];
  endfunction

  function automatic imm6_t imm6_of(instruction_t instr);
    return imm6_t'(instr[5:0]);
  endfunction

  function automatic addr_t jaddr_of(instruction_t instr);
    return instr[7:0];
  endfunction

endpackage : isa_pkg

`default_nettype wire

/* hdl/params_pkg.sv */
`default_nettype none

package params_pkg;

  localparam int ADDR_WIDTH    = 8;     // instruction address, word index
  localparam int DATA_WIDTH    = 16;    // register and alu width
  localparam int MEM_SIZE      = 256;   // instruction words
  localparam int REG_COUNT     = 8;
  localparam int REG_IDX_WIDTH = $clog2(REG_COUNT);

  // pc value the core starts fetching from
  localparam int RESET_PC      = 1;

  typedef logic [ADDR_WIDTH-1:0]    addr_t;
  typedef logic [DATA_WIDTH-1:0]    data_t;
  typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

endpackage : params_pkg

`default_nettype wire

/* hdl/regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module regfile (
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  input  wire params_pkg::reg_idx_t rs1_i,
  input  wire params_pkg::reg_idx_t rs2_i,
  output params_pkg::data_t        rs1_data_o,
  output params_pkg::data_t        rs2_data_o,
  input  wire isa_pkg::wb_t        wb_i
);

  import params_pkg::*;

  data_t regs_q [REG_COUNT];
  logic  wr_en;

  assign wr_en = wb_i.valid && (wb_i.rd != '0);   // r0 is read only

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wb_i.rd] <= wb_i.data;
    end
  end

  // writeback lands before the next decode, no bypass path
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule : regfile

`default_nettype wire

/* src.f */
hdl/params_pkg.sv
hdl/isa_pkg.sv
hdl/fetch_stage.sv
hdl/imem.sv
hdl/regfile.sv
hdl/execute_unit.sv
hdl/core_top.sv
dv/core_tb.sv
